/* logic/llc_regmap_pkg.sv */
/*
 * Register map of the cache configuration port.
 * Address encoding, the register word type and the version value
 * returned by the read-only Version register.
 */

package llc_regmap_pkg;

  // Word width of every software-visible register
  typedef logic [31:0] reg_data_t;

  // Register addresses, one per word
  typedef enum logic [3:0] {
    reg_cfg_spm     = 4'd0,
    reg_cfg_flush   = 4'd1,
    reg_commit_cfg  = 4'd2,
    reg_flushed     = 4'd3,
    reg_bist_out    = 4'd4,
    reg_bist_status = 4'd5,
    reg_num_ways    = 4'd6,
    reg_num_lines   = 4'd7,
    reg_num_blocks  = 4'd8,
    reg_version     = 4'd9
  } reg_addr_e;

  // Major in the upper half, minor in the lower half
  localparam reg_data_t llc_version = 32'h0001_0002;

endpackage

/* logic/llc_flush_pkg.sv */
/*
 * Flush sequencing definitions.
 * State encoding of the flush FSM, shared by the controller and the
 * property checks that observe it.
 */

package llc_flush_pkg;

  // Flush FSM states
  // Reset lands in pre_init, which waits for the tag-storage self-test
  typedef enum logic [2:0] {
    fsm_pre_init   = 3'd0,
    fsm_idle       = 3'd1,
    // Port isolation requested, waiting for acknowledge
    fsm_wait_ax    = 3'd2,
    // Waiting for AW/AR descriptor units to drain
    fsm_wait_units = 3'd3,
    // Pick remaining ways and arm the line counters
    fsm_init_flush = 3'd4,
    // One descriptor per accepted handshake
    fsm_send_flush = 3'd5,
    // Collect outstanding completions of the current way
    fsm_wait_flush = 3'd6,
    fsm_end_flush  = 3'd7
  } flush_state_e;

endpackage

/* logic/llc_cfg_regs.sv */
/*
 * Software-visible configuration registers of the cache.
 * Plain read/write port with combinational read, plus hardware update
 * strobes from the flush FSM that take priority over software writes.
 */

`timescale 1ns/1ps

module llc_cfg_regs
  import llc_regmap_pkg::*;
#(
  parameter int unsigned num_ways   = 4,
  parameter int unsigned index_bits = 3,
  parameter int unsigned num_blocks = 4
) (
  input  logic                rst_ni,
  input  logic                reset_i,
  // Software port
  input  reg_addr_e           reg_addr_i,
  input  reg_data_t           reg_wdata_i,
  input  logic                reg_we_i,
  output reg_data_t           reg_rdata_o,
  // Hardware updates from the flush FSM
  input  logic                sw_cfg_open_i,
  input  logic                hw_commit_clr_i,
  input  logic                hw_flushed_we_i,
  input  logic [num_ways-1:0] hw_flushed_val_i,
  input  logic                hw_flush_clr_i,
  input  logic                hw_spm_we_i,
  input  logic [num_ways-1:0] hw_spm_val_i,
  // Self-test result
  input  logic [num_ways-1:0] bist_res_i,
  input  logic                bist_valid_i,
  // Register contents towards the design
  output logic [num_ways-1:0] cfg_spm_o,
  output logic [num_ways-1:0] cfg_flush_o,
  output logic                commit_o,
  output logic [num_ways-1:0] flushed_o
);

  logic sw_we_spm, sw_we_flush, sw_we_commit;

  // Config words only open while the FSM sits in idle
  assign sw_we_spm    = reg_we_i && sw_cfg_open_i && (reg_addr_i == reg_cfg_spm);
  assign sw_we_flush  = reg_we_i && sw_cfg_open_i && (reg_addr_i == reg_cfg_flush);
  assign sw_we_commit = reg_we_i && (reg_addr_i == reg_commit_cfg);

  ////////////////////////////////////////////////////////////////////////////
  // Writable and hardware-updated registers
  ////////////////////////////////////////////////////////////////////////////
  always_ff @(posedge rst_ni) begin
    if (reset_i) begin
      cfg_spm_o   <= '0;
      cfg_flush_o <= '0;
      commit_o    <= 1'b0;
      flushed_o   <= '0;
    end else begin
      // Hardware branch checked first in each register
      if (hw_spm_we_i) begin
        cfg_spm_o <= hw_spm_val_i;
      end else if (sw_we_spm) begin
        cfg_spm_o <= reg_wdata_i[num_ways-1:0];
      end
      if (hw_flush_clr_i) begin
        cfg_flush_o <= '0;
      end else if (sw_we_flush) begin
        cfg_flush_o <= reg_wdata_i[num_ways-1:0];
      end
      if (hw_commit_clr_i) begin
        commit_o <= 1'b0;
      end else if (sw_we_commit) begin
        commit_o <= reg_wdata_i[0];
      end
      // Flushed is read-only from software
      if (hw_flushed_we_i) begin
        flushed_o <= hw_flushed_val_i;
      end
    end
  end

  // Read mux, zero-extended to the word, unmapped addresses read 0
  always_comb begin
    case (reg_addr_i)
      reg_cfg_spm:     reg_rdata_o = reg_data_t'(cfg_spm_o);
      reg_cfg_flush:   reg_rdata_o = reg_data_t'(cfg_flush_o);
      reg_commit_cfg:  reg_rdata_o = reg_data_t'(commit_o);
      reg_flushed:     reg_rdata_o = reg_data_t'(flushed_o);
      reg_bist_out:    reg_rdata_o = reg_data_t'(bist_res_i);
      reg_bist_status: reg_rdata_o = reg_data_t'(bist_valid_i);
      reg_num_ways:    reg_rdata_o = reg_data_t'(num_ways);
      reg_num_lines:   reg_rdata_o = reg_data_t'(1) << index_bits;
      reg_num_blocks:  reg_rdata_o = reg_data_t'(num_blocks);
      reg_version:     reg_rdata_o = llc_version;
      default:         reg_rdata_o = '0;
    endcase
  end

endmodule

/* logic/llc_flush_ctrl.sv */
/*
 * Flush FSM of the cache.
 * Isolates the cache port, latches the scratch-pad lock and walks every
 * selected way line by line, emitting valid/ready flush descriptors.
 */

`timescale 1ns/1ps

module llc_flush_ctrl
  import llc_flush_pkg::*;
#(
  parameter int unsigned num_ways         = 4,
  parameter int unsigned index_bits       = 3,
  parameter int unsigned line_offset_bits = 6,
  parameter int unsigned addr_width       = 32
) (
  input  logic                  rst_ni,
  input  logic                  reset_i,
  input  logic [num_ways-1:0]   cfg_spm_i,
  input  logic [num_ways-1:0]   cfg_flush_i,
  input  logic                  commit_i,
  input  logic [num_ways-1:0]   flushed_i,
  input  logic [num_ways-1:0]   bist_res_i,
  input  logic                  bist_valid_i,
  input  logic                  isolated_i,
  input  logic                  aw_busy_i,
  input  logic                  ar_busy_i,
  input  logic                  flush_ready_i,
  input  logic [index_bits-1:0] line_idx_i,
  input  logic                  last_sent_i,
  input  logic                  all_received_i,
  input  logic                  flush_done_i,
  output logic                  isolate_o,
  output logic                  sw_cfg_open_o,
  output logic                  hw_commit_clr_o,
  output logic                  hw_flushed_we_o,
  output logic [num_ways-1:0]   hw_flushed_val_o,
  output logic                  hw_flush_clr_o,
  output logic                  hw_spm_we_o,
  output logic [num_ways-1:0]   hw_spm_val_o,
  output logic [num_ways-1:0]   spm_lock_o,
  output logic                  flush_valid_o,
  output logic [addr_width-1:0] flush_addr_o,
  output logic [num_ways-1:0]   flush_way_o,
  output logic                  cnt_load_o,
  output logic                  cnt_clear_o,
  output logic                  send_en_o,
  output logic                  recv_en_o
);

  flush_state_e          state_q, state_d;
  logic [num_ways-1:0]   to_flush_q, to_flush_d;
  logic [num_ways-1:0]   to_flush_next;
  logic [addr_width-1:0] line_addr;
  logic                  spm_load;

  always_ff @(posedge rst_ni) begin
    if (reset_i) begin
      state_q    <= fsm_pre_init;
      to_flush_q <= '0;
      spm_lock_o <= '0;
    end else begin
      state_q    <= state_d;
      to_flush_q <= to_flush_d;
      if (spm_load) begin
        spm_lock_o <= cfg_spm_i;
      end
    end
  end

  // Requested ways minus those already flushed
  assign to_flush_next = (cfg_flush_i | cfg_spm_i) & ~flushed_i;

  // Lowest remaining way as one-hot, held stable through send and wait
  assign flush_way_o = to_flush_q & (~to_flush_q + 1'b1);

  // Line index placed above the in-line offset
  assign line_addr    = addr_width'(line_idx_i);
  assign flush_addr_o = line_addr << line_offset_bits;

  // Port only open in normal operation
  assign isolate_o     = (state_q != fsm_idle);
  assign sw_cfg_open_o = (state_q == fsm_idle);
  assign flush_valid_o = (state_q == fsm_send_flush);

  always_comb begin
    state_d          = state_q;
    to_flush_d       = to_flush_q;
    spm_load         = 1'b0;
    hw_commit_clr_o  = 1'b0;
    hw_flushed_we_o  = 1'b0;
    hw_flushed_val_o = flushed_i;
    hw_flush_clr_o   = 1'b0;
    hw_spm_we_o      = 1'b0;
    hw_spm_val_o     = bist_res_i;
    cnt_load_o       = 1'b0;
    cnt_clear_o      = 1'b0;
    send_en_o        = 1'b0;
    recv_en_o        = 1'b0;
    case (state_q)
      fsm_pre_init: begin
        // Faulty tag macros start out as SPM and marked flushed
        if (bist_valid_i) begin
          hw_spm_we_o      = 1'b1;
          hw_flushed_we_o  = 1'b1;
          hw_flushed_val_o = bist_res_i;
          state_d          = fsm_idle;
        end
      end
      fsm_idle: begin
        if (commit_i) begin
          hw_commit_clr_o = 1'b1;
          state_d         = fsm_wait_ax;
        end
      end
      fsm_wait_ax: begin
        if (isolated_i) begin
          state_d = fsm_wait_units;
        end
      end
      fsm_wait_units: begin
        // No functional descriptor in flight, safe to switch the lock
        if (!aw_busy_i && !ar_busy_i) begin
          spm_load = 1'b1;
          state_d  = fsm_init_flush;
        end
      end
      fsm_init_flush: begin
        to_flush_d = to_flush_next;
        if (to_flush_next == '0) begin
          hw_flush_clr_o = 1'b1;
          state_d        = fsm_idle;
        end else begin
          cnt_load_o = 1'b1;
          state_d    = fsm_send_flush;
        end
      end
      fsm_send_flush: begin
        // Index stays on the last line once it is accepted
        if (flush_ready_i) begin
          if (last_sent_i) begin
            state_d = fsm_wait_flush;
          end else begin
            send_en_o = 1'b1;
          end
        end
        recv_en_o = flush_done_i;
      end
      fsm_wait_flush: begin
        // Final completion is seen with the down counter at zero
        if (flush_done_i) begin
          if (all_received_i) begin
            state_d = fsm_end_flush;
          end else begin
            recv_en_o = 1'b1;
          end
        end
      end
      fsm_end_flush: begin
        cnt_clear_o     = 1'b1;
        hw_flushed_we_o = 1'b1;
        if (to_flush_q == flush_way_o) begin
          // Last way done, SPM ways stay flushed
          hw_flushed_val_o = cfg_spm_i;
          hw_flush_clr_o   = 1'b1;
          to_flush_d       = '0;
          state_d          = fsm_idle;
        end else begin
          hw_flushed_val_o = flushed_i | flush_way_o;
          state_d          = fsm_init_flush;
        end
      end
      default: state_d = fsm_pre_init;
    endcase
  end

endmodule

/* logic/llc_flush_tracker.sv */
/*
 * Line counters for one flushed way.
 * Up counter gives the line of the next descriptor, down counter holds
 * the completions still outstanding; both flag their end values.
 */

`timescale 1ns/1ps

module llc_flush_tracker #(
  parameter int unsigned index_bits = 3
) (
  input  logic                  rst_ni,
  input  logic                  reset_i,
  input  logic                  load_i,
  input  logic                  clear_i,
  input  logic                  send_en_i,
  input  logic                  recv_en_i,
  output logic [index_bits-1:0] line_idx_o,
  output logic                  last_sent_o,
  output logic                  all_received_o
);

  logic [index_bits-1:0] pending_q;

  //////////////////////////////////////////////////////////////////////////
  // Counters, clear before load before count
  //////////////////////////////////////////////////////////////////////////
  always_ff @(posedge rst_ni) begin
    if (reset_i || clear_i) begin
      line_idx_o <= '0;
      pending_q  <= '0;
    end else if (load_i) begin
      // Line count less one, last completion seen at zero
      line_idx_o <= '0;
      pending_q  <= '1;
    end else begin
      if (send_en_i) begin
        line_idx_o <= line_idx_o + 1'b1;
      end
      if (recv_en_i) begin
        pending_q <= pending_q - 1'b1;
      end
    end
  end

  assign last_sent_o    = (line_idx_o == '1);
  assign all_received_o = (pending_q == '0);

endmodule

/* logic/llc_bypass_decode.sv */
/*
 * Bypass steering for the AW and AR channels.
 * Region bounds are start inclusive, end exclusive; the SPM region is
 * matched first. Output 1 routes the burst around the cache.
 */

`timescale 1ns/1ps

module llc_bypass_decode #(
  parameter int unsigned num_ways   = 4,
  parameter int unsigned addr_width = 32
) (
  input  logic [addr_width-1:0] aw_addr_i,
  input  logic [addr_width-1:0] ar_addr_i,
  input  logic [addr_width-1:0] cached_start_i,
  input  logic [addr_width-1:0] cached_end_i,
  input  logic [addr_width-1:0] spm_start_i,
  input  logic [addr_width-1:0] spm_end_i,
  input  logic [num_ways-1:0]   flushed_i,
  output logic                  aw_bypass_o,
  output logic                  ar_bypass_o
);

  logic all_flushed;

  // With every way flushed the cache holds nothing worth a lookup
  assign all_flushed = &flushed_i;

  function automatic logic route_bypass(input logic [addr_width-1:0] addr);
    logic in_spm, in_cached;
    in_spm    = (addr >= spm_start_i) && (addr < spm_end_i);
    in_cached = (addr >= cached_start_i) && (addr < cached_end_i);
    // SPM always served by the cache
    if (in_spm) begin
      return 1'b0;
    end else if (in_cached) begin
      return all_flushed;
    end
    // Unmapped goes straight to memory
    return 1'b1;
  endfunction

  // Bounds and flushed state change the decision as well as the address
  always_comb begin
    aw_bypass_o = route_bypass(aw_addr_i);
    ar_bypass_o = route_bypass(ar_addr_i);
  end

endmodule

/* logic/llc_config_top.sv */
/*
 * Configuration and flush controller of the last-level cache.
 * Connects the register bank, the flush FSM, its line tracker and the
 * bypass decoder; all geometry parameters are set here.
 */

`timescale 1ns/1ps

module llc_config_top
  import llc_regmap_pkg::*;
#(
  parameter int unsigned num_ways         = 4,
  parameter int unsigned index_bits       = 3,
  parameter int unsigned line_offset_bits = 6,
  parameter int unsigned num_blocks       = 4,
  parameter int unsigned addr_width       = 32
) (
  input  logic                  rst_ni,
  input  logic                  reset_i,
  input  reg_addr_e             reg_addr_i,
  input  reg_data_t             reg_wdata_i,
  input  logic                  reg_we_i,
  output reg_data_t             reg_rdata_o,
  input  logic [num_ways-1:0]   bist_res_i,
  input  logic                  bist_valid_i,
  output logic                  isolate_o,
  input  logic                  isolated_i,
  input  logic                  aw_busy_i,
  input  logic                  ar_busy_i,
  output logic                  flush_valid_o,
  input  logic                  flush_ready_i,
  output logic [addr_width-1:0] flush_addr_o,
  output logic [num_ways-1:0]   flush_way_o,
  input  logic                  flush_done_i,
  input  logic [addr_width-1:0] aw_addr_i,
  input  logic [addr_width-1:0] ar_addr_i,
  input  logic [addr_width-1:0] cached_start_i,
  input  logic [addr_width-1:0] cached_end_i,
  input  logic [addr_width-1:0] spm_start_i,
  input  logic [addr_width-1:0] spm_end_i,
  output logic                  aw_bypass_o,
  output logic                  ar_bypass_o,
  output logic [num_ways-1:0]   spm_lock_o,
  output logic [num_ways-1:0]   flushed_o
);

  // Register bank <-> flush FSM
  logic [num_ways-1:0]   cfg_spm, cfg_flush, hw_flushed_val, hw_spm_val;
  logic                  commit, hw_commit_clr, hw_flushed_we, hw_flush_clr;
  logic                  hw_spm_we, sw_cfg_open;
  // Flush FSM <-> line tracker
  logic                  cnt_load, cnt_clear, send_en, recv_en;
  logic [index_bits-1:0] line_idx;
  logic                  last_sent, all_received;

  llc_cfg_regs #(
    .num_ways   (num_ways),
    .index_bits (index_bits),
    .num_blocks (num_blocks)
  ) u_regs (
    .rst_ni           (rst_ni),
    .reset_i          (reset_i),
    .reg_addr_i       (reg_addr_i),
    .reg_wdata_i      (reg_wdata_i),
    .reg_we_i         (reg_we_i),
    .reg_rdata_o      (reg_rdata_o),
    .sw_cfg_open_i    (sw_cfg_open),
    .hw_commit_clr_i  (hw_commit_clr),
    .hw_flushed_we_i  (hw_flushed_we),
    .hw_flushed_val_i (hw_flushed_val),
    .hw_flush_clr_i   (hw_flush_clr),
    .hw_spm_we_i      (hw_spm_we),
    .hw_spm_val_i     (hw_spm_val),
    .bist_res_i       (bist_res_i),
    .bist_valid_i     (bist_valid_i),
    .cfg_spm_o        (cfg_spm),
    .cfg_flush_o      (cfg_flush),
    .commit_o         (commit),
    .flushed_o        (flushed_o)
  );

  llc_flush_ctrl #(
    .num_ways         (num_ways),
    .index_bits       (index_bits),
    .line_offset_bits (line_offset_bits),
    .addr_width       (addr_width)
  ) u_ctrl (
    .rst_ni           (rst_ni),
    .reset_i          (reset_i),
    .cfg_spm_i        (cfg_spm),
    .cfg_flush_i      (cfg_flush),
    .commit_i         (commit),
    .flushed_i        (flushed_o),
    .bist_res_i       (bist_res_i),
    .bist_valid_i     (bist_valid_i),
    .isolated_i       (isolated_i),
    .aw_busy_i        (aw_busy_i),
    .ar_busy_i        (ar_busy_i),
    .flush_ready_i    (flush_ready_i),
    .line_idx_i       (line_idx),
    .last_sent_i      (last_sent),
    .all_received_i   (all_received),
    .flush_done_i     (flush_done_i),
    .isolate_o        (isolate_o),
    .sw_cfg_open_o    (sw_cfg_open),
    .hw_commit_clr_o  (hw_commit_clr),
    .hw_flushed_we_o  (hw_flushed_we),
    .hw_flushed_val_o (hw_flushed_val),
    .hw_flush_clr_o   (hw_flush_clr),
    .hw_spm_we_o      (hw_spm_we),
    .hw_spm_val_o     (hw_spm_val),
    .spm_lock_o       (spm_lock_o),
    .flush_valid_o    (flush_valid_o),
    .flush_addr_o     (flush_addr_o),
    .flush_way_o      (flush_way_o),
    .cnt_load_o       (cnt_load),
    .cnt_clear_o      (cnt_clear),
    .send_en_o        (send_en),
    .recv_en_o        (recv_en)
  );

  llc_flush_tracker #(
    .index_bits (index_bits)
  ) u_tracker (
    .rst_ni         (rst_ni),
    .reset_i        (reset_i),
    .load_i         (cnt_load),
    .clear_i        (cnt_clear),
    .send_en_i      (send_en),
    .recv_en_i      (recv_en),
    .line_idx_o     (line_idx),
    .last_sent_o    (last_sent),
    .all_received_o (all_received)
  );

  llc_bypass_decode #(
    .num_ways   (num_ways),
    .addr_width (addr_width)
  ) u_bypass (
    .aw_addr_i      (aw_addr_i),
    .ar_addr_i      (ar_addr_i),
    .cached_start_i (cached_start_i),
    .cached_end_i   (cached_end_i),
    .spm_start_i    (spm_start_i),
    .spm_end_i      (spm_end_i),
    .flushed_i      (flushed_o),
    .aw_bypass_o    (aw_bypass_o),
    .ar_bypass_o    (ar_bypass_o)
  );

endmodule

/* test/llc_config_props.sv */
/*
 * Protocol properties of the flush descriptor port and port isolation.
 * Bound into the cache configuration top level, reads the FSM state.
 */

`timescale 1ns/1ps

module llc_config_props
  import llc_flush_pkg::*;
#(
  parameter int unsigned num_ways   = 4,
  parameter int unsigned addr_width = 32
) (
  input  logic                  rst_ni,
  input  logic                  reset_i,
  input  logic                  isolate_i,
  input  logic                  flush_valid_i,
  input  logic                  flush_ready_i,
  input  logic [addr_width-1:0] flush_addr_i,
  input  logic [num_ways-1:0]   flush_way_i,
  input  logic                  flush_done_i,
  input  flush_state_e          state_i
);

  // Descriptors accepted and not yet completed
  logic [7:0] outstanding_q;

  always_ff @(posedge rst_ni) begin
    if (reset_i) begin
      outstanding_q <= '0;
    end else begin
      outstanding_q <= outstanding_q + 8'(flush_valid_i && flush_ready_i)
                       - 8'(flush_done_i);
    end
  end

  // Port stays isolated while a descriptor is offered or still owed a completion
  isolate_covers_flush: assert property (@(posedge rst_ni) disable iff (reset_i)
    flush_valid_i || (outstanding_q != '0) |-> isolate_i)
    else $error("cache port open with a flush descriptor offered or outstanding");

  // Offer held unchanged until accepted
  valid_payload_stable: assert property (@(posedge rst_ni) disable iff (reset_i)
    flush_valid_i && !flush_ready_i |=>
      flush_valid_i && $stable(flush_addr_i) && $stable(flush_way_i))
    else $error("flush descriptor changed before ready");

  // Exactly one way per descriptor
  way_onehot: assert property (@(posedge rst_ni) disable iff (reset_i)
    flush_valid_i |-> $onehot(flush_way_i))
    else $error("flush way is not one-hot");

  // Back in idle only once every completion has returned
  idle_nothing_outstanding: assert property (@(posedge rst_ni) disable iff (reset_i)
    state_i == fsm_idle |-> outstanding_q == '0)
    else $error("flush FSM idle with completions outstanding");

endmodule

bind llc_config_top llc_config_props #(
  .num_ways   (num_ways),
  .addr_width (addr_width)
) u_props (
  .rst_ni        (rst_ni),
  .reset_i       (reset_i),
  .isolate_i     (isolate_o),
  .flush_valid_i (flush_valid_o),
  .flush_ready_i (flush_ready_i),
  .flush_addr_i  (flush_addr_o),
  .flush_way_i   (flush_way_o),
  .flush_done_i  (flush_done_i),
  .state_i       (u_ctrl.state_q)
);

/* test/tb_llc_config.sv */
/*
 * Directed testbench of the cache configuration and flush controller.
 * A responder acknowledges isolation, stalls descriptors at random and
 * returns completions; each directed test is one task.
 */

`timescale 1ns/1ps

module tb_llc_config
  import llc_regmap_pkg::*;
();

  localparam int unsigned num_ways         = 4;
  localparam int unsigned index_bits       = 3;
  localparam int unsigned line_offset_bits = 6;
  localparam int unsigned num_blocks       = 4;
  localparam int unsigned addr_width       = 32;
  localparam int unsigned num_lines        = 1 << index_bits;

  // Budget of every way flushed at four cycles per line, per test
  localparam int test_count      = 5;
  localparam int cycles_per_test = num_ways * num_lines * 4;
  localparam int watchdog_cycles = test_count * cycles_per_test + 200;

  // Clock and reset
  logic                  rst_ni;
  logic                  reset_i;
  // Register port
  reg_addr_e             reg_addr_i;
  reg_data_t             reg_wdata_i;
  logic                  reg_we_i;
  reg_data_t             reg_rdata_o;
  // Self-test, isolation and flush port
  logic [num_ways-1:0]   bist_res_i;
  logic                  bist_valid_i;
  logic                  isolate_o, isolated_i, aw_busy_i, ar_busy_i;
  logic                  flush_valid_o, flush_ready_i, flush_done_i;
  logic [addr_width-1:0] flush_addr_o;
  logic [num_ways-1:0]   flush_way_o;
  // Bypass steering
  logic [addr_width-1:0] aw_addr_i, ar_addr_i;
  logic [addr_width-1:0] cached_start_i, cached_end_i, spm_start_i, spm_end_i;
  logic                  aw_bypass_o, ar_bypass_o;
  logic [num_ways-1:0]   spm_lock_o, flushed_o;

  integer                seed;
  int                    check_count, error_count;
  logic [1:0]            done_pipe;
  // Descriptors seen on the port, in order
  logic [addr_width-1:0] got_addr[$];
  logic [num_ways-1:0]   got_way[$];
  // Expected register contents
  logic [num_ways-1:0]   model_spm, model_flush, model_flushed;

  llc_config_top #(
    .num_ways         (num_ways),
    .index_bits       (index_bits),
    .line_offset_bits (line_offset_bits),
    .num_blocks       (num_blocks),
    .addr_width       (addr_width)
  ) dut0 (.*);

  initial begin
    rst_ni = 1'b0;
    forever #50 rst_ni = ~rst_ni;
  end

  ////////////////////////////////////////////////////////////////////////////
  // Responder for isolation, back-pressure and completions
  ////////////////////////////////////////////////////////////////////////////
  always @(negedge rst_ni) begin
    isolated_i    = isolate_o;
    flush_ready_i = ($random(seed) & 3) != 0;
    // Completion two cycles after the transfer edge
    flush_done_i  = done_pipe[1];
    done_pipe[1]  = done_pipe[0];
    done_pipe[0]  = flush_valid_o && flush_ready_i;
    // Valid and ready now hold through the next rising edge
    if (flush_valid_o && flush_ready_i) begin
      got_addr.push_back(flush_addr_o);
      got_way.push_back(flush_way_o);
    end
  end

  task automatic check_eq(input string what, input logic [31:0] got,
                          input logic [31:0] exp);
    check_count++;
    assert (got === exp) else begin
      error_count++;
      $display("CHECK FAILED at %0t ns: %s is %0h, expected %0h", $time, what, got, exp);
    end
  endtask

  task automatic write_reg(input reg_addr_e addr, input reg_data_t data);
    @(negedge rst_ni);
    reg_addr_i  = addr;
    reg_wdata_i = data;
    reg_we_i    = 1'b1;
    @(negedge rst_ni);
    reg_we_i    = 1'b0;
  endtask

  // Read is combinational, sampled well before the next rising edge
  task automatic expect_reg(input reg_addr_e addr, input reg_data_t exp);
    @(negedge rst_ni);
    reg_addr_i = addr;
    #10;
    check_eq(addr.name(), reg_rdata_o, exp);
  endtask

  task automatic wait_isolate(input logic level);
    int cycles;
    cycles = 0;
    while (isolate_o !== level && cycles < cycles_per_test * 2) begin
      @(negedge rst_ni);
      cycles++;
    end
    assert (isolate_o === level) else begin
      error_count++;
      $display("Timeout: isolate_o did not reach %0b within %0d cycles", level, cycles);
    end
  endtask

  task automatic check_bypass(input logic [addr_width-1:0] addr, input logic exp,
                              input string what);
    @(negedge rst_ni);
    aw_addr_i = addr;
    ar_addr_i = addr;
    #10;
    check_eq({"aw_bypass_o, ", what}, aw_bypass_o, exp);
    check_eq({"ar_bypass_o, ", what}, ar_bypass_o, exp);
  endtask

  // Commit, run the whole flush and compare every descriptor
  task automatic commit_flush(input int busy_cycles, input logic [num_ways-1:0] ways);
    logic [addr_width-1:0] exp_addr[$];
    logic [num_ways-1:0]   exp_way[$];
    // Lowest way first, every line of it in order
    for (int w = 0; w < num_ways; w++) begin
      if (ways[w]) begin
        for (int l = 0; l < num_lines; l++) begin
          exp_addr.push_back(addr_width'(l) << line_offset_bits);
          exp_way.push_back(num_ways'(1) << w);
        end
      end
    end
    got_addr.delete();
    got_way.delete();
    @(negedge rst_ni);
    aw_busy_i = (busy_cycles > 0);
    ar_busy_i = (busy_cycles > 0);
    write_reg(reg_commit_cfg, 32'd1);
    wait_isolate(1'b1);
    if (busy_cycles > 0) begin
      // Config words are closed while the flush runs
      write_reg(reg_cfg_spm, 32'hf);
      write_reg(reg_cfg_flush, 32'hf);
    end
    repeat (busy_cycles) @(negedge rst_ni);
    if (busy_cycles > 0) begin
      check_eq("descriptors while units busy", got_addr.size(), 0);
    end
    aw_busy_i = 1'b0;
    ar_busy_i = 1'b0;
    wait_isolate(1'b0);
    check_eq("descriptor count", got_addr.size(), exp_addr.size());
    foreach (exp_addr[i]) begin
      if (i < got_addr.size()) begin
        check_eq($sformatf("descriptor %0d address", i), got_addr[i], exp_addr[i]);
        check_eq($sformatf("descriptor %0d way", i), got_way[i], exp_way[i]);
      end
    end
    // Scratch-pad ways stay flushed, request cleared
    model_flushed = model_spm;
    model_flush   = '0;
    check_eq("spm_lock_o", spm_lock_o, model_spm);
    check_eq("flushed_o", flushed_o, model_flushed);
    expect_reg(reg_flushed, model_flushed);
    expect_reg(reg_cfg_flush, model_flush);
  endtask

  ////////////////////////////////////////////////////////////////////////////
  // Directed tests
  ////////////////////////////////////////////////////////////////////////////
  task automatic test_self_test();
    // Still in pre-init right after reset
    check_eq("isolate_o after reset", isolate_o, 1'b1);
    check_eq("flush_valid_o after reset", flush_valid_o, 1'b0);
    expect_reg(reg_cfg_spm, '0);
    expect_reg(reg_flushed, '0);
    @(negedge rst_ni);
    bist_res_i   = 4'b0010;
    bist_valid_i = 1'b1;
    wait_isolate(1'b0);
    model_spm     = 4'b0010;
    model_flushed = 4'b0010;
    expect_reg(reg_cfg_spm, model_spm);
    expect_reg(reg_flushed, model_flushed);
    expect_reg(reg_bist_out, 32'h2);
    expect_reg(reg_bist_status, 32'h1);
    expect_reg(reg_num_ways, num_ways);
    expect_reg(reg_num_lines, num_lines);
    expect_reg(reg_num_blocks, num_blocks);
    expect_reg(reg_version, llc_version);
  endtask

  task automatic test_write_gating();
    write_reg(reg_cfg_spm, 32'h5);
    write_reg(reg_cfg_flush, 32'ha);
    expect_reg(reg_cfg_spm, 32'h5);
    expect_reg(reg_cfg_flush, 32'ha);
    // Read-only words keep their value
    write_reg(reg_flushed, 32'hf);
    write_reg(reg_version, 32'hdead_beef);
    expect_reg(reg_flushed, model_flushed);
    expect_reg(reg_version, llc_version);
    write_reg(reg_cfg_spm, 32'h0);
    write_reg(reg_cfg_flush, 32'h0);
    model_spm = '0;
    expect_reg(reg_cfg_spm, 32'h0);
  endtask

  task automatic test_explicit_flush();
    write_reg(reg_cfg_flush, 32'h9);
    model_flush = 4'b1001;
    // Busy units hold the FSM before the lock is taken
    commit_flush(4, 4'b1001);
    check_eq("isolate_o after flush", isolate_o, 1'b0);
  endtask

  task automatic test_spm_lock();
    write_reg(reg_cfg_spm, 32'h4);
    model_spm = 4'b0100;
    commit_flush(0, 4'b0100);
  endtask

  task automatic test_bypass();
    check_bypass(32'h1000_0000, 1'b0, "SPM start");
    check_bypass(32'h1000_ffff, 1'b0, "SPM last byte");
    check_bypass(32'h1001_0000, 1'b1, "SPM end");
    check_bypass(32'h8000_0000, 1'b0, "cached start");
    check_bypass(32'h8fff_fffc, 1'b0, "cached last word");
    check_bypass(32'h9000_0000, 1'b1, "cached end");
    check_bypass(32'h0000_0040, 1'b1, "unmapped");
    // Every way turned into SPM, way 2 is already flushed
    write_reg(reg_cfg_spm, 32'hf);
    model_spm = 4'b1111;
    commit_flush(0, 4'b1011);
    check_bypass(32'h8000_0000, 1'b1, "cached start, all flushed");
    check_bypass(32'h8abc_0100, 1'b1, "cached middle, all flushed");
    check_bypass(32'h1000_0100, 1'b0, "SPM, all flushed");
    // Nothing left to flush, the request is dropped straight away
    write_reg(reg_cfg_flush, 32'h3);
    model_flush = 4'b0011;
    commit_flush(0, 4'b0000);
  endtask

  ////////////////////////////////////////////////////////////////////////////
  // Sequence and summary
  ////////////////////////////////////////////////////////////////////////////
  initial begin
    seed           = 32'hd6cc_9301;
    check_count    = 0;
    error_count    = 0;
    done_pipe      = '0;
    reset_i        = 1'b1;
    reg_addr_i     = reg_cfg_spm;
    reg_wdata_i    = '0;
    reg_we_i       = 1'b0;
    bist_res_i     = '0;
    bist_valid_i   = 1'b0;
    isolated_i     = 1'b0;
    aw_busy_i      = 1'b0;
    ar_busy_i      = 1'b0;
    flush_ready_i  = 1'b0;
    flush_done_i   = 1'b0;
    aw_addr_i      = '0;
    ar_addr_i      = '0;
    cached_start_i = 32'h8000_0000;
    cached_end_i   = 32'h9000_0000;
    spm_start_i    = 32'h1000_0000;
    spm_end_i      = 32'h1001_0000;
    model_spm      = '0;
    model_flush    = '0;
    model_flushed  = '0;
    repeat (5) @(posedge rst_ni);
    @(negedge rst_ni);
    reset_i = 1'b0;
    test_self_test();
    test_write_gating();
    test_explicit_flush();
    test_spm_lock();
    test_bypass();
    $display("Summary: %0d checks run, %0d errors", check_count, error_count);
    if (error_count == 0) begin
      $display("ALL CHECKS PASSED");
    end else begin
      $display("CHECKS FAILED");
    end
    $finish;
  end

  // Watchdog
  initial begin
    repeat (watchdog_cycles) @(posedge rst_ni);
    $display("Timeout: run exceeded %0d cycles and was stopped", watchdog_cycles);
    $display("Summary: %0d checks run, %0d errors", check_count, error_count);
    $display("CHECKS FAILED");
    $finish;
  end

endmodule

/* src.f */
logic/llc_regmap_pkg.sv
logic/llc_flush_pkg.sv
logic/llc_cfg_regs.sv
logic/llc_flush_ctrl.sv
logic/llc_flush_tracker.sv
logic/llc_bypass_decode.sv
logic/llc_config_top.sv
test/llc_config_props.sv
test/tb_llc_config.sv

/* Makefile */
SIM       = verilator
SIM_FLAGS = --binary --timing --assert -Wno-fatal
TOP       = tb_llc_config
FILELIST  = src.f
BUILD_DIR = obj_dir
LOG       = sim.log

.PHONY: sim clean

sim:
	$(SIM) $(SIM_FLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(BUILD_DIR)
	./$(BUILD_DIR)/V$(TOP) | tee $(LOG)
	grep -q "^ALL CHECKS PASSED$$" $(LOG)

clean:
	rm -rf $(BUILD_DIR) $(LOG)
